// File: rtl/cam_bist_pkg.sv
// Shared constants and codes for the CAM BIST
// Defaults describe a 16 x 8 CAM with a 4-bit address
// Read and search latency of the array is fixed at pipe_depth cycles
// Patterns are 8 bits wide and get resized where dwidth differs

package cam_bist_pkg;

  // ====================
  // Array geometry defaults
  // ====================
  localparam int cam_entries = 16;
  localparam int cam_dwidth  = 8;
  localparam int cam_awidth  = 4;

  // Cycles from rd_en or srch_en to valid array output
  localparam int pipe_depth = 2;

  // Data backgrounds for the all-match and single-mismatch phases
  localparam logic [7:0] pat_fill = 8'hA5;
  localparam logic [7:0] pat_alt  = 8'h5A;

  // ====================
  // Reference pattern select
  // ====================
  typedef enum logic [1:0] {
    all_match       = 2'b00,
    single_match    = 2'b01,
    single_mismatch = 2'b10,
    all_mismatch    = 2'b11
  } match_sel_e;

  // ====================
  // Sequencer phases
  // ====================
  // Code 6 is unused, 7 marks idle and the closing cycle
  typedef enum logic [2:0] {
    ph_write      = 3'd0,
    ph_read       = 3'd1,
    ph_single     = 3'd2,
    ph_miss       = 3'd3,
    ph_allmatch   = 3'd4,
    ph_singlemiss = 3'd5,
    ph_idle       = 3'd7
  } bist_phase_e;

endpackage

// File: rtl/cam_array.sv
// Behavioural binary CAM, one write, one read and one search port
// rd_data and match_lines are valid two cycles after their enables
// A write is visible to a read or search issued in the next cycle
// Stuck-at fault forces one stored bit, fault_bit must stay below dwidth
// Storage has no reset, contents are unknown until written

`timescale 1ns/100ps

module cam_array #(
  parameter int entries = 16,
  parameter int dwidth  = 8,
  parameter int awidth  = 4
) (
  input  logic                bist_clk,
  input  logic                rst,
  input  logic                wr_en,
  input  logic [awidth-1:0]   wr_addr,
  input  logic [dwidth-1:0]   wr_data,
  input  logic                rd_en,
  input  logic [awidth-1:0]   rd_addr,
  input  logic                srch_en,
  input  logic [dwidth-1:0]   srch_key,
  input  logic                fault_en,
  input  logic [awidth-1:0]   fault_entry,
  input  logic [2:0]          fault_bit,
  input  logic                fault_val,
  output logic [dwidth-1:0]   rd_data,
  output logic [entries-1:0]  match_lines
);

  logic [entries-1:0][dwidth-1:0] mem;
  // Contents as seen by the read and search logic
  logic [entries-1:0][dwidth-1:0] mem_view;
  logic [dwidth-1:0]              rd_q1;
  logic [entries-1:0]             match_q1;

  // ====================
  // Storage
  // ====================
  always_ff @(posedge bist_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Stuck-at override on the selected cell
  always_comb begin
    mem_view = mem;
    if (fault_en) begin
      mem_view[fault_entry][fault_bit] = fault_val;
    end
  end

  // ====================
  // Read pipeline
  // ====================
  always_ff @(posedge bist_clk) begin
    if (rd_en) begin
      rd_q1 <= mem_view[rd_addr];
    end
    rd_data <= rd_q1;
  end

  // ====================
  // Search pipeline
  // ====================
  // Match lines stay low in cycles without a search
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      match_q1    <= '0;
      match_lines <= '0;
    end else begin
      for (int i = 0; i < entries; i++) begin
        match_q1[i] <= srch_en && (mem_view[i] == srch_key);
      end
      match_lines <= match_q1;
    end
  end

endmodule

// File: rtl/cam_mbist_ctrl.sv
// Fixed march sequencer for the CAM BIST, one operation per cycle
// start is taken only while the phase is idle, including the closing cycle
// Every comparing phase ends with two drain cycles, nothing is issued there
// cm_mode and match_sel hold for the whole phase, drain cycles included
// A run lasts 154 sequence cycles plus one closing cycle before done

`timescale 1ns/100ps

module cam_mbist_ctrl
  import cam_bist_pkg::*;
#(
  parameter int entries = 16,
  parameter int dwidth  = 8,
  parameter int awidth  = 4
) (
  input  logic               bist_clk,
  input  logic               rst,
  input  logic               start,
  output logic               busy,
  output logic               done,
  output bist_phase_e        phase,
  output logic               wr_en,
  output logic [awidth-1:0]  wr_addr,
  output logic [dwidth-1:0]  wr_data,
  output logic               rd_en,
  output logic [awidth-1:0]  rd_addr,
  output logic               srch_en,
  output logic [dwidth-1:0]  srch_key,
  output logic               cm_mode,
  output match_sel_e         match_sel,
  output logic [awidth-1:0]  ref_addr,
  output logic               cmp_en,
  output logic [dwidth-1:0]  exp_data
);

  localparam logic [awidth-1:0] last_addr = awidth'(entries - 1);

  logic [awidth-1:0] addr;
  // Step within ph_singlemiss: 0 write alt, 1 search, 2 restore
  logic [1:0]        sub;
  // 0 while issuing, then 1 and 2 for the drain cycles
  logic [1:0]        drain;
  // ph_allmatch runs a fill pass then a search pass
  logic              half;
  logic              issue;
  logic              last;
  bist_phase_e       next_phase;

  assign issue    = busy && (drain == 2'd0);
  assign last     = (addr == last_addr);
  assign ref_addr = addr;
  assign wr_addr  = addr;
  assign rd_addr  = addr;

  // ====================
  // Operation decode
  // ====================
  always_comb begin
    wr_en     = 1'b0;
    wr_data   = '0;
    rd_en     = 1'b0;
    srch_en   = 1'b0;
    srch_key  = '0;
    cmp_en    = 1'b0;
    exp_data  = '0;
    cm_mode   = 1'b0;
    match_sel = all_match;
    case (phase)
      ph_write: begin
        wr_en   = issue;
        wr_data = dwidth'(addr);
      end
      ph_read: begin
        rd_en    = issue;
        cmp_en   = issue;
        exp_data = dwidth'(addr);
      end
      ph_single: begin
        cm_mode   = 1'b1;
        match_sel = single_match;
        srch_en   = issue;
        cmp_en    = issue;
        srch_key  = dwidth'(addr);
      end
      ph_miss: begin
        cm_mode   = 1'b1;
        match_sel = all_mismatch;
        srch_en   = issue;
        cmp_en    = issue;
        srch_key  = '1;
      end
      ph_allmatch: begin
        cm_mode  = 1'b1;
        wr_data  = dwidth'(pat_fill);
        srch_key = dwidth'(pat_fill);
        wr_en    = issue && !half;
        srch_en  = issue && half;
        cmp_en   = issue && half;
      end
      ph_singlemiss: begin
        cm_mode   = 1'b1;
        match_sel = single_mismatch;
        srch_key  = dwidth'(pat_fill);
        wr_data   = (sub == 2'd0) ? dwidth'(pat_alt) : dwidth'(pat_fill);
        wr_en     = issue && (sub != 2'd1);
        srch_en   = issue && (sub == 2'd1);
        cmp_en    = issue && (sub == 2'd1);
      end
      default: begin
      end
    endcase
  end

  // Phase that follows the drain of the current one
  always_comb begin
    case (phase)
      ph_read:     next_phase = ph_single;
      ph_single:   next_phase = ph_miss;
      ph_miss:     next_phase = ph_allmatch;
      ph_allmatch: next_phase = ph_singlemiss;
      default:     next_phase = ph_idle;
    endcase
  end

  // ====================
  // Phase state machine
  // ====================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      phase <= ph_idle;
      busy  <= 1'b0;
      done  <= 1'b0;
      addr  <= '0;
      sub   <= '0;
      drain <= '0;
      half  <= 1'b0;
    end else if (start && phase == ph_idle) begin
      phase <= ph_write;
      busy  <= 1'b1;
      done  <= 1'b0;
      addr  <= '0;
      sub   <= '0;
      drain <= '0;
      half  <= 1'b0;
    end else if (busy) begin
      if (phase == ph_idle) begin
        // Closing cycle, last compare has already been judged
        busy <= 1'b0;
        done <= 1'b1;
      end else if (drain == 2'd2) begin
        drain <= '0;
        phase <= next_phase;
      end else if (drain != 2'd0) begin
        drain <= drain + 2'd1;
      end else if (phase == ph_singlemiss && sub != 2'd2) begin
        sub <= sub + 2'd1;
      end else begin
        sub  <= '0;
        addr <= last ? '0 : addr + 1'b1;
        if (last) begin
          if (phase == ph_write) begin
            // Write pass needs no drain, nothing to compare
            phase <= ph_read;
          end else if (phase == ph_allmatch && !half) begin
            half <= 1'b1;
          end else begin
            drain <= 2'd1;
          end
        end
      end
    end
  end

endmodule

// File: rtl/cam_bist_outhandler.sv
// Match-line test logic for the CAM BIST
// Reference address is delayed two cycles to line up with match_lines
// cm_mode and match_sel are taken as they stand in the compare cycle
// Compare result is ORed down to dwidth bits, or padded when narrower
// No reset, all state here is a pure delay line

`timescale 1ns/100ps

module cam_bist_outhandler
  import cam_bist_pkg::*;
#(
  parameter int entries = 16,
  parameter int dwidth  = 8,
  parameter int awidth  = 4
) (
  input  logic                bist_clk,
  input  logic                cm_mode,
  input  match_sel_e          match_sel,
  input  logic [awidth-1:0]   ref_addr,
  input  logic [entries-1:0]  match_lines,
  input  logic [dwidth-1:0]   rd_data,
  output logic [dwidth-1:0]   rd_data_out,
  output logic [entries-1:0]  match_ref
);

  logic [awidth-1:0]  addr_q1;
  logic [awidth-1:0]  addr_q2;
  logic [entries-1:0] one_hot;
  logic [entries-1:0] cmp_vec;
  logic [dwidth-1:0]  cmp_data;

  // ====================
  // Reference vector
  // ====================
  always_ff @(posedge bist_clk) begin
    addr_q1 <= ref_addr;
    addr_q2 <= addr_q1;
  end

  assign one_hot = entries'(1) << addr_q2;

  always_comb begin
    unique case (match_sel)
      all_match:       match_ref = '1;
      single_match:    match_ref = one_hot;
      single_mismatch: match_ref = ~one_hot;
      all_mismatch:    match_ref = '0;
      default:         match_ref = '0;
    endcase
  end

  // Any set bit marks an entry whose match line is wrong
  assign cmp_vec = match_ref ^ match_lines;

  // ====================
  // Fold onto data width
  // ====================
  if (entries > dwidth) begin : g_compact
    localparam int groups = (entries + dwidth - 1) / dwidth;
    logic [groups*dwidth-1:0] padded;

    // Top group is zero filled when entries is not a multiple of dwidth
    always_comb begin
      padded = '0;
      padded[entries-1:0] = cmp_vec;
      cmp_data = '0;
      for (int g = 0; g < groups; g++) begin
        cmp_data = cmp_data | padded[g*dwidth +: dwidth];
      end
    end
  end else if (entries == dwidth) begin : g_equal
    assign cmp_data = cmp_vec;
  end else begin : g_expand
    // Result sits in the upper bits, low bits read as zero
    assign cmp_data = {cmp_vec, {(dwidth-entries){1'b0}}};
  end

  // Search result replaces read data in CAM mode
  assign rd_data_out = cm_mode ? cmp_data : rd_data;

endmodule

// File: rtl/cam_bist_checker.sv
// Result checker for the CAM BIST
// Expectations are delayed pipe_depth cycles to meet the array output
// fail is sticky, phase and address belong to the first mismatch only
// start clears the result only while the sequencer phase is idle

`timescale 1ns/100ps

module cam_bist_checker
  import cam_bist_pkg::*;
#(
  parameter int dwidth = 8,
  parameter int awidth = 4
) (
  input  logic               bist_clk,
  input  logic               rst,
  input  logic               start,
  input  logic               cmp_en,
  input  logic [dwidth-1:0]  exp_data,
  input  bist_phase_e        phase,
  input  logic [awidth-1:0]  ref_addr,
  input  logic [dwidth-1:0]  rd_data_out,
  output logic               fail,
  output bist_phase_e        fail_phase,
  output logic [awidth-1:0]  fail_addr
);

  logic [pipe_depth-1:0]              cmp_q;
  logic [pipe_depth-1:0][dwidth-1:0]  exp_q;
  bist_phase_e                        phase_q [pipe_depth];
  logic [pipe_depth-1:0][awidth-1:0]  addr_q;
  logic                               mismatch;

  // ====================
  // Expectation delay
  // ====================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      cmp_q <= '0;
    end else begin
      cmp_q <= {cmp_q[pipe_depth-2:0], cmp_en};
    end
    exp_q[0]   <= exp_data;
    phase_q[0] <= phase;
    addr_q[0]  <= ref_addr;
    for (int i = 1; i < pipe_depth; i++) begin
      exp_q[i]   <= exp_q[i-1];
      phase_q[i] <= phase_q[i-1];
      addr_q[i]  <= addr_q[i-1];
    end
  end

  assign mismatch = cmp_q[pipe_depth-1] && (rd_data_out != exp_q[pipe_depth-1]);

  // ====================
  // First fail capture
  // ====================
  always_ff @(posedge bist_clk) begin
    if (rst || (start && phase == ph_idle)) begin
      fail       <= 1'b0;
      fail_phase <= ph_idle;
      fail_addr  <= '0;
    end else if (mismatch && !fail) begin
      fail       <= 1'b1;
      fail_phase <= phase_q[pipe_depth-1];
      fail_addr  <= addr_q[pipe_depth-1];
    end
  end

endmodule

// File: rtl/cam_bist_top.sv
// CAM with its BIST sequencer, output handler and checker
// Geometry comes from the package defaults and is passed down
// Fault inputs go straight to the array fault model
// Results are valid while done is high

`timescale 1ns/100ps

module cam_bist_top
  import cam_bist_pkg::*;
#(
  parameter int entries = cam_entries,
  parameter int dwidth  = cam_dwidth,
  parameter int awidth  = cam_awidth
) (
  input  logic                bist_clk,
  input  logic                rst,
  input  logic                start,
  input  logic                fault_en,
  input  logic [awidth-1:0]   fault_entry,
  input  logic [2:0]          fault_bit,
  input  logic                fault_val,
  output logic                busy,
  output logic                done,
  output logic                fail,
  output bist_phase_e         fail_phase,
  output logic [awidth-1:0]   fail_addr,
  output logic [entries-1:0]  match_ref
);

  // Sequencer outputs
  bist_phase_e        phase;
  logic               wr_en;
  logic [awidth-1:0]  wr_addr;
  logic [dwidth-1:0]  wr_data;
  logic               rd_en;
  logic [awidth-1:0]  rd_addr;
  logic               srch_en;
  logic [dwidth-1:0]  srch_key;
  logic               cm_mode;
  match_sel_e         match_sel;
  logic [awidth-1:0]  ref_addr;
  logic               cmp_en;
  logic [dwidth-1:0]  exp_data;
  // Array and handler outputs
  logic [dwidth-1:0]  rd_data;
  logic [entries-1:0] match_lines;
  logic [dwidth-1:0]  rd_data_out;

  cam_mbist_ctrl #(
    .entries (entries),
    .dwidth  (dwidth),
    .awidth  (awidth)
  ) u_ctrl (
    .bist_clk  (bist_clk),
    .rst       (rst),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .phase     (phase),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .srch_en   (srch_en),
    .srch_key  (srch_key),
    .cm_mode   (cm_mode),
    .match_sel (match_sel),
    .ref_addr  (ref_addr),
    .cmp_en    (cmp_en),
    .exp_data  (exp_data)
  );

  cam_array #(
    .entries (entries),
    .dwidth  (dwidth),
    .awidth  (awidth)
  ) u_array (
    .bist_clk    (bist_clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .srch_en     (srch_en),
    .srch_key    (srch_key),
    .fault_en    (fault_en),
    .fault_entry (fault_entry),
    .fault_bit   (fault_bit),
    .fault_val   (fault_val),
    .rd_data     (rd_data),
    .match_lines (match_lines)
  );

  cam_bist_outhandler #(
    .entries (entries),
    .dwidth  (dwidth),
    .awidth  (awidth)
  ) u_outhandler (
    .bist_clk    (bist_clk),
    .cm_mode     (cm_mode),
    .match_sel   (match_sel),
    .ref_addr    (ref_addr),
    .match_lines (match_lines),
    .rd_data     (rd_data),
    .rd_data_out (rd_data_out),
    .match_ref   (match_ref)
  );

  cam_bist_checker #(
    .dwidth (dwidth),
    .awidth (awidth)
  ) u_checker (
    .bist_clk    (bist_clk),
    .rst         (rst),
    .start       (start),
    .cmp_en      (cmp_en),
    .exp_data    (exp_data),
    .phase       (phase),
    .ref_addr    (ref_addr),
    .rd_data_out (rd_data_out),
    .fail        (fail),
    .fail_phase  (fail_phase),
    .fail_addr   (fail_addr)
  );

endmodule

// File: verification/cam_bist_chk.sv
// Protocol properties of the BIST sequencer and checker
// Bound at the BIST top, where both sets of outputs meet
// Properties are off while reset is high

`timescale 1ns/100ps

module cam_bist_chk (
  input logic bist_clk,
  input logic rst,
  input logic busy,
  input logic done,
  input logic wr_en,
  input logic rd_en,
  input logic srch_en,
  input logic fail
);

  // ====================
  // Sequencer
  // ====================
  // Running and finished never overlap
  busy_done_excl: assert property (@(posedge bist_clk) disable iff (rst)
    !(busy && done))
    else $error("busy and done high in the same cycle");

  // At most one array operation per cycle
  one_op: assert property (@(posedge bist_clk) disable iff (rst)
    $onehot0({wr_en, rd_en, srch_en}))
    else $error("more than one array operation issued");

  // ====================
  // Checker
  // ====================
  // Result holds until the next accepted start
  fail_hold: assert property (@(posedge bist_clk) disable iff (rst)
    done |-> !$fell(fail))
    else $error("fail dropped while done was high");

endmodule

bind cam_bist_top cam_bist_chk u_chk (
  .bist_clk (bist_clk),
  .rst      (rst),
  .busy     (busy),
  .done     (done),
  .wr_en    (wr_en),
  .rd_en    (rd_en),
  .srch_en  (srch_en),
  .fail     (fail)
);

// File: verification/cam_bist_tb.sv
// Testbench for the CAM BIST top level
// Fault inputs change only while the BIST is idle, before each start
// Expected results come from a replay of the march on a model array
// Random faults come from an 8-bit Galois LFSR seeded with 4

`timescale 1ns/100ps

module cam_bist_tb
  import cam_bist_pkg::*;
();

  localparam int clk_period  = 4;
  localparam int run_cycles  = 160;
  localparam int max_runs    = 20;
  localparam int done_cycles = 155;
  // First ph_single search, after the write pass and the drained read pass
  localparam int single_first = 2 * cam_entries + 2;

  logic                    bist_clk;
  logic                    rst;
  logic                    start;
  logic                    fault_en;
  logic [cam_awidth-1:0]   fault_entry;
  logic [2:0]              fault_bit;
  logic                    fault_val;
  logic                    busy;
  logic                    done;
  logic                    fail;
  bist_phase_e             fail_phase;
  logic [cam_awidth-1:0]   fail_addr;
  logic [cam_entries-1:0]  match_ref;

  // Handed from stimulus to compare once per run
  string                   test_name;
  logic                    exp_fail;
  bist_phase_e             exp_phase;
  logic [cam_awidth-1:0]   exp_addr;
  logic                    fail_at_start;
  logic                    busy_bad;
  logic                    check_trace;
  logic                    run_ready;
  int                      cycles_seen;
  logic [cam_entries-1:0]  ref_trace [run_cycles+1];
  logic [7:0]              lfsr;
  int                      tests;
  int                      errors;

  cam_bist_top dut0 (
    .bist_clk    (bist_clk),
    .rst         (rst),
    .start       (start),
    .fault_en    (fault_en),
    .fault_entry (fault_entry),
    .fault_bit   (fault_bit),
    .fault_val   (fault_val),
    .busy        (busy),
    .done        (done),
    .fail        (fail),
    .fail_phase  (fail_phase),
    .fail_addr   (fail_addr),
    .match_ref   (match_ref)
  );

  initial begin
    bist_clk = 1'b0;
    forever #(clk_period / 2) bist_clk = ~bist_clk;
  end

  // ====================
  // Reference model
  // ====================
  // Stored value as the array sees it, stuck cell forced
  function automatic logic [cam_dwidth-1:0] stuck(input logic [cam_dwidth-1:0] v, input int i);
    logic [cam_dwidth-1:0] r;
    r = v;
    if (fault_en && i == int'(fault_entry)) begin
      r[fault_bit] = fault_val;
    end
    return r;
  endfunction

  // True when any entry's match differs from the wanted pattern
  function automatic logic search_bad(input logic [cam_entries-1:0][cam_dwidth-1:0] mem,
                                      input logic [cam_dwidth-1:0] key,
                                      input logic [cam_entries-1:0] want);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < cam_entries; i++) begin
      if ((stuck(mem[i], i) == key) != want[i]) begin
        bad = 1'b1;
      end
    end
    return bad;
  endfunction

  // Replays the march, first mismatch in sequence order wins
  function automatic void predict(output logic e_fail, output bist_phase_e e_phase,
                                  output logic [cam_awidth-1:0] e_addr);
    logic [cam_entries-1:0][cam_dwidth-1:0] mem;
    logic                                   bad;
    e_fail  = 1'b0;
    e_phase = ph_idle;
    e_addr  = '0;
    // Contents after ph_write
    for (int i = 0; i < cam_entries; i++) begin
      mem[i] = cam_dwidth'(i);
    end
    // Phase codes 1 to 5 follow the table order
    for (int ph = 1; ph <= 5; ph++) begin
      if (ph == 4) begin
        // Fill pass of ph_allmatch
        mem = {cam_entries{8'hA5}};
      end
      for (int a = 0; a < cam_entries; a++) begin
        case (ph)
          1: bad = stuck(mem[a], a) != cam_dwidth'(a);
          2: bad = search_bad(mem, cam_dwidth'(a), cam_entries'(1) << a);
          3: bad = search_bad(mem, 8'hFF, '0);
          4: bad = search_bad(mem, 8'hA5, '1);
          default: begin
            // Write alt, search fill, restore fill
            mem[a] = 8'h5A;
            bad    = search_bad(mem, 8'hA5, ~(cam_entries'(1) << a));
            mem[a] = 8'hA5;
          end
        endcase
        if (bad && !e_fail) begin
          e_fail  = 1'b1;
          e_phase = bist_phase_e'(ph);
          e_addr  = cam_awidth'(a);
        end
      end
    end
  endfunction

  // ====================
  // Stimulus helpers
  // ====================
  // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // One step per bit taken, first bit ends up in the MSB
  task automatic draw_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  // Called on a falling edge, returns once the compare process is through
  task automatic run_test(input string name, input logic en, input logic [cam_awidth-1:0] ent,
                          input logic [2:0] bit_sel, input logic val, input logic trace);
    int cyc;
    fault_en    = en;
    fault_entry = ent;
    fault_bit   = bit_sel;
    fault_val   = val;
    test_name   = name;
    check_trace = trace;
    predict(exp_fail, exp_phase, exp_addr);
    start = 1'b1;
    @(negedge bist_clk);
    start = 1'b0;
    // First state of the run
    fail_at_start = fail;
    ref_trace[0]  = match_ref;
    // busy is high until done, and low once done is up
    busy_bad = (done == busy);
    cyc = 0;
    while (!done && cyc < run_cycles) begin
      @(negedge bist_clk);
      cyc++;
      ref_trace[cyc] = match_ref;
      if (done == busy) begin
        busy_bad = 1'b1;
      end
    end
    cycles_seen = cyc;
    run_ready   = 1'b1;
    wait (!run_ready);
    @(negedge bist_clk);
  endtask

  // ====================
  // Compare
  // ====================
  initial begin : compare
    int errs_before;
    forever begin
      wait (run_ready);
      errs_before = errors;
      assert (cycles_seen == done_cycles) else begin
        $display("ERROR %0t: %s, done after %0d cycles, expected %0d", $time, test_name,
                 cycles_seen, done_cycles);
        errors++;
      end
      assert (!busy_bad) else begin
        $display("ERROR %0t: %s, busy not high from start up to done", $time, test_name);
        errors++;
      end
      assert (!fail_at_start) else begin
        $display("ERROR %0t: %s, fail still set after start", $time, test_name);
        errors++;
      end
      assert (fail == exp_fail) else begin
        $display("ERROR %0t: %s, fail %0b, expected %0b", $time, test_name, fail, exp_fail);
        errors++;
      end
      if (exp_fail) begin
        assert (fail_phase == exp_phase && fail_addr == exp_addr) else begin
          $display("ERROR %0t: %s, first fail %s at %0d, expected %s at %0d", $time,
                   test_name, fail_phase.name(), fail_addr, exp_phase.name(), exp_addr);
          errors++;
        end
      end
      if (check_trace) begin
        // Search of address k is issued at single_first + k, seen two cycles on
        for (int k = 0; k < cam_entries; k++) begin
          assert (ref_trace[single_first + 2 + k] == (cam_entries'(1) << k)) else begin
            $display("ERROR %0t: %s, match_ref %h for search address %0d", $time, test_name,
                     ref_trace[single_first + 2 + k], k);
            errors++;
          end
        end
      end
      tests++;
      $display("%s: %s", test_name, (errors == errs_before) ? "pass" : "fail");
      run_ready = 1'b0;
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial begin : stimulus
    logic [7:0] ent;
    logic [7:0] bsel;
    logic [7:0] val;
    rst         = 1'b1;
    start       = 1'b0;
    fault_en    = 1'b0;
    fault_entry = '0;
    fault_bit   = '0;
    fault_val   = 1'b0;
    run_ready   = 1'b0;
    tests       = 0;
    errors      = 0;
    lfsr        = 8'd4;
    repeat (8) @(posedge bist_clk);
    @(negedge bist_clk);
    rst = 1'b0;
    @(negedge bist_clk);
    run_test("no fault", 1'b0, 4'd0, 3'd0, 1'b0, 1'b0);
    // Entry 6 bit 1 stuck at 0 reads back as 4
    run_test("read fault", 1'b1, 4'd6, 3'd1, 1'b0, 1'b0);
    // Entry 11 bit 1 stuck at 1 agrees with 0B, turns A5 into A7
    run_test("search fault", 1'b1, 4'd11, 3'd1, 1'b1, 1'b0);
    // Follows a failing run, also traces match_ref in ph_single
    run_test("restart clean", 1'b0, 4'd0, 3'd0, 1'b0, 1'b1);
    for (int n = 0; n < 10; n++) begin
      draw_bits(cam_awidth, ent);
      draw_bits(3, bsel);
      draw_bits(1, val);
      run_test($sformatf("random fault %0d", n), 1'b1, ent[cam_awidth-1:0], bsel[2:0],
               val[0], 1'b0);
    end
    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Budget covers every run plus the reset cycles
  initial begin : watchdog
    #((max_runs * run_cycles + 8) * clk_period);
    $display("Watchdog expired, the BIST runs did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: cam_bist_top.f
rtl/cam_bist_pkg.sv
rtl/cam_array.sv
rtl/cam_mbist_ctrl.sv
rtl/cam_bist_outhandler.sv
rtl/cam_bist_checker.sv
rtl/cam_bist_top.sv
verification/cam_bist_chk.sv
verification/cam_bist_tb.sv

// File: Makefile
# Verilator flow for the CAM BIST testbench

TOP := cam_bist_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cam_bist_top.f rtl/*.sv verification/*.sv
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f cam_bist_top.f

# Pass only when the simulation prints the pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -Wall \
		--top-module $(TOP) -f cam_bist_top.f

clean:
	rm -rf obj_dir
